//--- build.f
+incdir+.
gnn_pkg.sv
rs2pe_if.sv
vertex_rs.sv
vertex_sequencer.sv
vertex_pe_array.sv
vertex_out_buffer.sv
gnn_vertex_top.sv
gnn_props.sv
tb_gnn_vertex.sv

//--- gnn_defines.svh
`ifndef GNN_DEFINES_SVH
`define GNN_DEFINES_SVH

// bits per feature element
`define FV_SIZE 8

// elements per feature vector
`define MAX_FV_NUM 8

// nodes per batch, one vertex lane each
`define NUM_EDGE_PE 4

// elements per input beat and per lane step
`define MULT_PER_PE 2

// node id range, ids are log2 of this wide
`define MAX_NODE_ID 16

// dot-product width, eight 16-bit products fit
`define ACC_SIZE 20

`endif

//--- gnn_pkg.sv
`default_nettype none

`include "gnn_defines.svh"

package gnn_pkg;

    // one feature element, unsigned
    typedef logic [`FV_SIZE-1:0] fv_t;

    // elements [0] and [1] of one step, [0] is the lower index
    typedef fv_t [`MULT_PER_PE-1:0] fv_pair_t;

    // node id as sent by the feature bank
    typedef logic [$clog2(`MAX_NODE_ID)-1:0] node_id_t;

    // element position inside a vector
    typedef logic [$clog2(`MAX_FV_NUM)-1:0] fv_idx_t;

    // per-node dot product
    typedef logic [`ACC_SIZE-1:0] acc_t;

endpackage

`default_nettype wire

//--- gnn_props.sv
`timescale 1ns/100ps
`default_nettype none

module gnn_props (
    input logic clk,
    input logic reset,
    input logic in_sos,
    input logic fire,
    input logic rs_available,
    input logic vertex_buf_idle
);

    // fire is a single-cycle strobe
    a_fire_pulse: assert property (@(posedge clk) disable iff (reset) fire |=> !fire)
        else $error("fire held for more than one cycle");

    // source respects the station
    a_sos_open: assert property (@(posedge clk) disable iff (reset) in_sos |-> rs_available)
        else $error("in_sos while rs_available low");

    // closed right after fire
    a_closed: assert property (@(posedge clk) disable iff (reset) fire |=> !rs_available)
        else $error("rs_available high after fire");

    // reopens only with the buffer idle
    a_reopen: assert property (@(posedge clk) disable iff (reset)
        $rose(rs_available) |-> vertex_buf_idle)
        else $error("rs_available rose while the buffer was busy");

endmodule

bind vertex_rs gnn_props u_props (
    .clk             (clk),
    .reset           (reset),
    .in_sos          (in_sos),
    .fire            (fire),
    .rs_available    (rs_available),
    .vertex_buf_idle (vertex_buf_idle)
);

`default_nettype wire

//--- gnn_vertex_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_defines.svh"

module gnn_vertex_top import gnn_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_sos,
    input  logic     in_eos,
    input  fv_t      in_fv_0,
    input  fv_t      in_fv_1,
    input  node_id_t in_node_id,
    output logic     rs_available,
    input  logic     w_we,
    input  fv_idx_t  w_idx,
    input  fv_t      w_data,
    output logic     out_valid,
    output node_id_t out_node_id,
    output acc_t     out_result
);

    // station to sequencer and back
    logic fire;
    fv_idx_t start_idx;
    logic idx_valid;
    logic complete;

    // pe array to buffer, and buffer idle to station
    logic result_valid;
    acc_t [`NUM_EDGE_PE-1:0] result;
    node_id_t [`NUM_EDGE_PE-1:0] result_node_id;
    logic vertex_buf_idle;

    rs2pe_if u_rs2pe ();

    vertex_rs u_rs (
        .clk             (clk),
        .reset           (reset),
        .in_sos          (in_sos),
        .in_eos          (in_eos),
        .in_fv_0         (in_fv_0),
        .in_fv_1         (in_fv_1),
        .in_node_id      (in_node_id),
        .start_idx       (start_idx),
        .idx_valid       (idx_valid),
        .complete        (complete),
        .vertex_buf_idle (vertex_buf_idle),
        .fire            (fire),
        .rs_available    (rs_available),
        .pe              (u_rs2pe.rs)
    );

    vertex_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .fire      (fire),
        .start_idx (start_idx),
        .idx_valid (idx_valid),
        .complete  (complete)
    );

    vertex_pe_array u_pe (
        .clk            (clk),
        .reset          (reset),
        .pe             (u_rs2pe.pe),
        .w_we           (w_we),
        .w_idx          (w_idx),
        .w_data         (w_data),
        .result_valid   (result_valid),
        .result         (result),
        .result_node_id (result_node_id)
    );

    vertex_out_buffer u_obuf (
        .clk             (clk),
        .reset           (reset),
        .result_valid    (result_valid),
        .result          (result),
        .result_node_id  (result_node_id),
        .out_valid       (out_valid),
        .out_result      (out_result),
        .out_node_id     (out_node_id),
        .vertex_buf_idle (vertex_buf_idle)
    );

endmodule

`default_nettype wire

//--- rs2pe_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_defines.svh"

interface rs2pe_if import gnn_pkg::*; ();

    // one step per cycle, no back-pressure
    logic valid;
    // final pair of the batch
    logic last;
    // element index of fv_pair[lane][0]
    fv_idx_t fv_idx;
    fv_pair_t [`NUM_EDGE_PE-1:0] fv_pair;
    node_id_t [`NUM_EDGE_PE-1:0] node_id;

    // station side
    modport rs (
        output valid,
        output last,
        output fv_idx,
        output fv_pair,
        output node_id
    );

    // processing element side
    modport pe (
        input valid,
        input last,
        input fv_idx,
        input fv_pair,
        input node_id
    );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run with Verilator, everything goes to sim.log
rm -rf obj_dir sim.log
{ verilator --binary --assert -Wno-fatal -f build.f --top-module tb_gnn_vertex -o tb_sim &&
    ./obj_dir/tb_sim; } > sim.log 2>&1 || echo "sim failed" >> sim.log
# build errors and assertion stops count as failures too
grep -q "sim failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }

//--- tb_gnn_vertex.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_defines.svh"

module tb_gnn_vertex import gnn_pkg::*; ();

    // tests 2 to 5 are one batch each, test 6 is twenty
    localparam int NUM_BATCHES = 24;
    localparam int BATCH_CYCLES = 80;
    localparam int WATCHDOG_CYCLES = NUM_BATCHES * BATCH_CYCLES + 100;
    localparam int NUM_TESTS = 6;

    logic clk = 1'b0;
    logic reset;
    logic in_sos;
    logic in_eos;
    fv_t in_fv_0;
    fv_t in_fv_1;
    node_id_t in_node_id;
    logic rs_available;
    logic w_we;
    fv_idx_t w_idx;
    fv_t w_data;
    logic out_valid;
    node_id_t out_node_id;
    acc_t out_result;

    logic [31:0] lcg_state = 32'd878;
    // copy of the weights the DUT holds
    fv_t tb_weight [`MAX_FV_NUM];
    acc_t exp_result_q [$];
    node_id_t exp_id_q [$];
    int error_count = 0;
    int fail_tests = 0;

    // monitor state
    int cyc = 0;
    int eos_seen = 0;
    int edge_e = 0;
    int last_out = 0;
    int batch_out = 0;
    logic busy = 1'b0;

    gnn_vertex_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .in_sos       (in_sos),
        .in_eos       (in_eos),
        .in_fv_0      (in_fv_0),
        .in_fv_1      (in_fv_1),
        .in_node_id   (in_node_id),
        .rs_available (rs_available),
        .w_we         (w_we),
        .w_idx        (w_idx),
        .w_data       (w_data),
        .out_valid    (out_valid),
        .out_node_id  (out_node_id),
        .out_result   (out_result)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // lcg, upper half is returned
    function logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // dot product of a zero-filled vector with the weights
    function automatic acc_t ref_dot(input fv_t vec [`MAX_FV_NUM]);
        acc_t sum;
        sum = '0;
        for (int i = 0; i < `MAX_FV_NUM; i++) begin
            sum = sum + acc_t'(vec[i]) * acc_t'(tb_weight[i]);
        end
        return sum;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // fresh random weights, one element per strobe
    task automatic load_weights();
        fv_t w;
        for (int i = 0; i < `MAX_FV_NUM; i++) begin
            w = fv_t'(next_rand());
            tb_weight[i] = w;
            @(posedge clk);
            w_we <= 1'b1;
            w_idx <= fv_idx_t'(i);
            w_data <= w;
        end
        @(posedge clk);
        w_we <= 1'b0;
    endtask

    // one node of len beats, two elements per beat
    task automatic send_node(input int len, input node_id_t id);
        fv_t vec [`MAX_FV_NUM];
        for (int i = 0; i < `MAX_FV_NUM; i++) begin
            vec[i] = '0;
        end
        for (int i = 0; i < 2 * len; i++) begin
            vec[i] = fv_t'(next_rand());
        end
        @(posedge clk);
        // sos only when the station is open
        while (!rs_available) begin
            in_sos <= 1'b0;
            in_eos <= 1'b0;
            @(posedge clk);
        end
        for (int k = 0; k < len; k++) begin
            if (k > 0) begin
                @(posedge clk);
            end
            in_sos <= (k == 0);
            in_eos <= (k == len - 1);
            in_fv_0 <= vec[2 * k];
            in_fv_1 <= vec[2 * k + 1];
            in_node_id <= id;
        end
        exp_result_q.push_back(ref_dot(vec));
        exp_id_q.push_back(id);
    endtask

    // results drain, then the station reopens
    task automatic finish_batch();
        int waited;
        waited = 0;
        @(posedge clk);
        in_sos <= 1'b0;
        in_eos <= 1'b0;
        while (!(rs_available && exp_result_q.size() == 0) && waited < BATCH_CYCLES) begin
            waited++;
            @(posedge clk);
        end
        if (waited >= BATCH_CYCLES) begin
            error_count++;
            $display("batch did not drain: %0d results still missing", exp_result_q.size());
        end
    endtask

    task automatic run_batch(input int l0, input int l1, input int l2, input int l3);
        int lens [`NUM_EDGE_PE];
        lens[0] = l0;
        lens[1] = l1;
        lens[2] = l2;
        lens[3] = l3;
        load_weights();
        for (int n = 0; n < `NUM_EDGE_PE; n++) begin
            send_node(lens[n], node_id_t'(next_rand()));
        end
        finish_batch();
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (error_count != errs_before) begin
            fail_tests++;
        end
        $display("test %s: %s", name, (error_count == errs_before) ? "ok" : "errors");
    endtask

    initial begin
        int errs;
        reset = 1'b1;
        in_sos = 1'b0;
        in_eos = 1'b0;
        in_fv_0 = '0;
        in_fv_1 = '0;
        in_node_id = '0;
        w_we = 1'b0;
        w_idx = '0;
        w_data = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        errs = error_count;
        @(posedge clk);
        compare_value("rs_available", rs_available, 1);
        compare_value("out_valid", out_valid, 0);
        end_test("1 reset state", errs);

        errs = error_count;
        run_batch(4, 4, 4, 4);
        end_test("2 full-length batch", errs);

        // short nodes right after full ones, stale data would show
        errs = error_count;
        run_batch(1, 2, 3, 1);
        end_test("3 short nodes", errs);

        errs = error_count;
        run_batch(2, 4, 1, 3);
        end_test("4 station closed while busy", errs);

        errs = error_count;
        run_batch(3, 1, 4, 2);
        end_test("5 output latency", errs);

        errs = error_count;
        for (int b = 0; b < 20; b++) begin
            run_batch(int'(next_rand() % 16'd4) + 1, int'(next_rand() % 16'd4) + 1,
                      int'(next_rand() % 16'd4) + 1, int'(next_rand() % 16'd4) + 1);
        end
        end_test("6 random batches", errs);

        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, fail_tests, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // output checker, values sampled at the rising edge
    always @(posedge clk) begin
        cyc++;
        if (!reset) begin
            // the edge that samples every fourth eos is edge E
            if (in_eos) begin
                eos_seen++;
                if (eos_seen % `NUM_EDGE_PE == 0) begin
                    edge_e = cyc;
                    busy = 1'b1;
                end
            end
            if (busy && cyc > edge_e && rs_available) begin
                error_count++;
                $display("rs_available high before the batch results left");
            end
            if (out_valid) begin
                if (!busy || exp_result_q.size() == 0) begin
                    error_count++;
                    $display("out_valid seen before the fourth node ended");
                end else begin
                    // out_valid raised by edge E+8 is seen here at E+9
                    if (batch_out == 0) begin
                        compare_value("out_valid latency", cyc - edge_e - 1, 8);
                    end else begin
                        compare_value("out_valid spacing", cyc - last_out, 1);
                    end
                    last_out = cyc;
                    compare_value("out_node_id", out_node_id, exp_id_q.pop_front());
                    compare_value("out_result", out_result, exp_result_q.pop_front());
                    batch_out++;
                    if (batch_out == `NUM_EDGE_PE) begin
                        batch_out = 0;
                        busy = 1'b0;
                    end
                end
            end
        end
    end

    // bound from the number of batches
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vertex_out_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_defines.svh"

module vertex_out_buffer import gnn_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          result_valid,
    input  acc_t [`NUM_EDGE_PE-1:0]       result,
    input  node_id_t [`NUM_EDGE_PE-1:0]   result_node_id,
    output logic                          out_valid,
    output acc_t                          out_result,
    output node_id_t                      out_node_id,
    output logic                          vertex_buf_idle
);

    localparam int CNT_W = $clog2(`NUM_EDGE_PE) + 1;

    acc_t [`NUM_EDGE_PE-1:0] held;
    node_id_t [`NUM_EDGE_PE-1:0] held_id;
    // results still to send
    logic [CNT_W-1:0] held_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_cnt <= '0;
        end else if (result_valid) begin
            held_cnt <= CNT_W'(`NUM_EDGE_PE);
        end else if (held_cnt != '0) begin
            held_cnt <= held_cnt - 1'b1;
        end
    end

    // lane 0 is at the head, shift toward it
    always_ff @(posedge clk) begin
        if (result_valid) begin
            held <= result;
            held_id <= result_node_id;
        end else if (held_cnt != '0) begin
            for (int i = 0; i < `NUM_EDGE_PE - 1; i++) begin
                held[i] <= held[i + 1];
                held_id[i] <= held_id[i + 1];
            end
        end
    end

    assign out_valid = (held_cnt != '0);
    assign out_result = held[0];
    assign out_node_id = held_id[0];
    // idle once the last result has left
    assign vertex_buf_idle = (held_cnt == '0);

endmodule

`default_nettype wire

//--- vertex_pe_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_defines.svh"

module vertex_pe_array import gnn_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    rs2pe_if.pe                           pe,
    input  logic                          w_we,
    input  fv_idx_t                       w_idx,
    input  fv_t                           w_data,
    output logic                          result_valid,
    output acc_t [`NUM_EDGE_PE-1:0]       result,
    output node_id_t [`NUM_EDGE_PE-1:0]   result_node_id
);

    // shared weight vector, one element per write
    fv_t weight [`MAX_FV_NUM];
    acc_t [`NUM_EDGE_PE-1:0] acc;
    acc_t [`NUM_EDGE_PE-1:0] lane_sum;

    always_ff @(posedge clk) begin
        if (w_we) begin
            weight[w_idx] <= w_data;
        end
    end

    // running sum plus this step's products
    always_comb begin
        for (int l = 0; l < `NUM_EDGE_PE; l++) begin
            lane_sum[l] = acc[l];
            for (int j = 0; j < `MULT_PER_PE; j++) begin
                lane_sum[l] = lane_sum[l]
                    + acc_t'(pe.fv_pair[l][j]) * acc_t'(weight[pe.fv_idx + fv_idx_t'(j)]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= pe.valid && pe.last;
            if (pe.valid) begin
                // restart for the next batch on last
                acc <= pe.last ? '0 : lane_sum;
            end
        end
    end

    // final sums and ids, one per lane
    always_ff @(posedge clk) begin
        if (pe.valid && pe.last) begin
            result <= lane_sum;
            result_node_id <= pe.node_id;
        end
    end

endmodule

`default_nettype wire

//--- vertex_rs.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_defines.svh"

module vertex_rs import gnn_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_sos,
    input  logic     in_eos,
    input  fv_t      in_fv_0,
    input  fv_t      in_fv_1,
    input  node_id_t in_node_id,
    input  fv_idx_t  start_idx,
    input  logic     idx_valid,
    input  logic     complete,
    input  logic     vertex_buf_idle,
    output logic     fire,
    output logic     rs_available,
    rs2pe_if.rs      pe
);

    localparam int SLOT_W = $clog2(`NUM_EDGE_PE);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`NUM_EDGE_PE - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RECEIVE,
        S_WAIT_VERTEX,
        S_WAIT_BUF
    } rs_state_t;

    rs_state_t state;
    logic [SLOT_W-1:0] slot;
    fv_idx_t elem_pos;
    fv_idx_t elem_pos_hi;
    fv_idx_t pick_hi;
    logic beat;
    logic issue;
    logic buf_seen_busy;
    logic buf_release;
    fv_t [`NUM_EDGE_PE-1:0][`MAX_FV_NUM-1:0] fv_store;
    node_id_t [`NUM_EDGE_PE-1:0] id_store;

    // idle also covers the gap between nodes of one batch
    // slot keeps track of how many nodes are in
    assign rs_available = (state == S_IDLE);

    // sos beat from idle, or any beat while a node is open
    assign beat = (state == S_IDLE && in_sos) || (state == S_RECEIVE);
    assign elem_pos_hi = elem_pos + fv_idx_t'(1);

    // pair selection while the sequencer walks
    assign issue = (state == S_WAIT_VERTEX) && idx_valid;
    assign pick_hi = start_idx + fv_idx_t'(1);

    // buffer is idle before its results arrive too,
    // so wait until it has been seen busy once
    assign buf_release = (state == S_WAIT_BUF) && vertex_buf_idle && buf_seen_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            slot <= '0;
            elem_pos <= '0;
            fire <= 1'b0;
            buf_seen_busy <= 1'b0;
        end else begin
            fire <= 1'b0;
            case (state)
                S_IDLE, S_RECEIVE: begin
                    if (beat && in_eos) begin
                        elem_pos <= '0;
                        if (slot == LAST_SLOT) begin
                            // batch full
                            state <= S_WAIT_VERTEX;
                            slot <= '0;
                            fire <= 1'b1;
                        end else begin
                            state <= S_IDLE;
                            slot <= slot + 1'b1;
                        end
                    end else if (beat) begin
                        state <= S_RECEIVE;
                        elem_pos <= elem_pos + fv_idx_t'(`MULT_PER_PE);
                    end
                end
                S_WAIT_VERTEX: begin
                    if (issue && complete) begin
                        state <= S_WAIT_BUF;
                        buf_seen_busy <= 1'b0;
                    end
                end
                S_WAIT_BUF: begin
                    if (!vertex_buf_idle) begin
                        buf_seen_busy <= 1'b1;
                    end
                    if (buf_release) begin
                        state <= S_IDLE;
                        slot <= '0;
                        elem_pos <= '0;
                        buf_seen_busy <= 1'b0;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // zeroed between batches so short nodes read zero
    always_ff @(posedge clk) begin
        if (reset || buf_release) begin
            fv_store <= '0;
            id_store <= '0;
        end else if (beat) begin
            fv_store[slot][elem_pos] <= in_fv_0;
            fv_store[slot][elem_pos_hi] <= in_fv_1;
            if (state == S_IDLE) begin
                id_store[slot] <= in_node_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pe.valid <= 1'b0;
            pe.last <= 1'b0;
        end else begin
            pe.valid <= issue;
            pe.last <= issue && complete;
        end
    end

    // one pair per lane, taken at start_idx
    always_ff @(posedge clk) begin
        if (issue) begin
            pe.fv_idx <= start_idx;
            for (int l = 0; l < `NUM_EDGE_PE; l++) begin
                pe.fv_pair[l][0] <= fv_store[l][start_idx];
                pe.fv_pair[l][1] <= fv_store[l][pick_hi];
                pe.node_id[l] <= id_store[l];
            end
        end
    end

endmodule

`default_nettype wire

//--- vertex_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_defines.svh"

module vertex_sequencer import gnn_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    fire,
    output fv_idx_t start_idx,
    output logic    idx_valid,
    output logic    complete
);

    localparam fv_idx_t LAST_IDX = fv_idx_t'(`MAX_FV_NUM - `MULT_PER_PE);

    logic run;
    fv_idx_t next_idx;

    // fire arms the walk, first index one edge later
    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
            next_idx <= '0;
            idx_valid <= 1'b0;
            complete <= 1'b0;
        end else begin
            idx_valid <= run;
            complete <= run && (next_idx == LAST_IDX);
            if (fire) begin
                run <= 1'b1;
                next_idx <= '0;
            end else if (run) begin
                next_idx <= next_idx + fv_idx_t'(`MULT_PER_PE);
                // stop after the last pair position
                if (next_idx == LAST_IDX) begin
                    run <= 1'b0;
                end
            end
        end
    end

    // index payload, qualified by idx_valid
    always_ff @(posedge clk) begin
        if (run && !fire) begin
            start_idx <= next_idx;
        end
    end

endmodule

`default_nettype wire
